// File: hw/bnn_conv_pkg.sv
// fixed 3x3 kernel and 16-bit rows, so images are limited to 3..16 rows and columns
`default_nettype none

package bnn_conv_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// vector types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory address, shared by all three memories
	typedef logic [11:0] addr_t;
	// one memory word, image row or output row or dimension
	typedef logic [15:0] word_t;
	// column position within a row
	typedef logic [3:0]  col_idx_t;
	// weight bit 3*dy+dx meets input row r+dy, column c+dx
	typedef logic [8:0]  kernel_t;
	// mismatches in one window, 0 to 9
	typedef logic [3:0]  count_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// constants
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// row-count word that ends a run
	localparam word_t END_MARKER     = 16'h00FF;
	// kernel bits live here, address 0 is never read
	localparam addr_t WEIGHT_ADDR    = 12'd1;
	localparam int    KERNEL_SIZE    = 3;
	// highest mismatch count still giving a 1
	localparam int    MAJORITY_LIMIT = 4;
	// column in to result at the writer
	localparam int    ARRAY_DEPTH    = 4;

	// controller states
	typedef enum logic [3:0] {
		IDLE,
		LOAD_WEIGHTS,
		READ_ROWS,
		READ_COLS,
		FILL_ROWS,
		SWEEP,
		DRAIN,
		WRITE_ROW,
		NEXT_ROW
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/conv_ctrl_if.sv
// single-cycle strobes with no acknowledge, status is only meaningful in the states that read it
`timescale 1ns/10ps
`default_nettype none

interface conv_ctrl_if;

	// strobes from the controller
	logic load_weights;
	logic store_rows;
	logic store_cols;
	// shift read word into the row buffer, bump read address
	logic fill_row;
	// next column into the array
	logic sweep;
	logic flush_row;
	// prime read address for the next image
	logic next_image;

	// status from the datapath
	// row-count word just read is the marker
	logic end_seen;
	// this sweep carries the final column
	logic last_col;
	// buffer holds the last three image rows
	logic last_row;

	modport controller (
		output load_weights, store_rows, store_cols, fill_row, sweep, flush_row, next_image,
		input  end_seen, last_col, last_row
	);

	modport datapath (
		input  load_weights, store_rows, store_cols, fill_row, sweep, flush_row, next_image,
		output end_seen, last_col, last_row
	);

endinterface

`default_nettype wire

// File: hw/conv_controller.sv
// run is a one-cycle strobe sampled only in IDLE, a strobe while busy is dropped
`timescale 1ns/10ps
`default_nettype none

module conv_controller import bnn_conv_pkg::*; (
	input  wire         clk,
	input  wire         reset_b,
	input  wire         run,
	output logic        busy,
	conv_ctrl_if.controller ctl
);

	// shared count for the fill reads and the drain wait
	typedef logic [$clog2(ARRAY_DEPTH)-1:0] step_t;

	ctrl_state_e state_q;
	ctrl_state_e state_n;
	step_t       step_q;
	logic        step_done;

	// fill ends after three reads, drain after the array depth
	always_comb begin
		step_done = 1'b0;
		if (state_q == FILL_ROWS)
			step_done = (step_q == step_t'(KERNEL_SIZE - 1));
		else if (state_q == DRAIN)
			step_done = (step_q == step_t'(ARRAY_DEPTH - 1));
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state and strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_n          = state_q;
		ctl.load_weights = 1'b0;
		ctl.store_rows   = 1'b0;
		ctl.store_cols   = 1'b0;
		ctl.fill_row     = 1'b0;
		ctl.sweep        = 1'b0;
		ctl.flush_row    = 1'b0;
		ctl.next_image   = 1'b0;
		case (state_q)
			IDLE: begin
				if (run)
					state_n = LOAD_WEIGHTS;
			end
			LOAD_WEIGHTS: begin
				// kernel fetch, also primes the read address
				ctl.load_weights = 1'b1;
				state_n          = READ_ROWS;
			end
			READ_ROWS: begin
				// captured even on the marker, which rewinds the read address
				ctl.store_rows = 1'b1;
				state_n        = ctl.end_seen ? IDLE : READ_COLS;
			end
			READ_COLS: begin
				ctl.store_cols = 1'b1;
				state_n        = FILL_ROWS;
			end
			FILL_ROWS: begin
				ctl.fill_row = 1'b1;
				if (step_done)
					state_n = SWEEP;
			end
			SWEEP: begin
				ctl.sweep = 1'b1;
				if (ctl.last_col)
					state_n = DRAIN;
			end
			DRAIN: begin
				// wait for the last column to clear the array
				if (step_done)
					state_n = WRITE_ROW;
			end
			WRITE_ROW: begin
				ctl.flush_row  = 1'b1;
				ctl.next_image = ctl.last_row;
				state_n        = ctl.last_row ? READ_ROWS : NEXT_ROW;
			end
			NEXT_ROW: begin
				// one more row slides into the window
				ctl.fill_row = 1'b1;
				state_n      = SWEEP;
			end
			default: state_n = IDLE;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state_q <= IDLE;
			step_q  <= '0;
			busy    <= 1'b0;
		end else begin
			state_q <= state_n;
			// counts only while fill or drain is still going
			if ((state_q == FILL_ROWS || state_q == DRAIN) && !step_done)
				step_q <= step_q + 1'b1;
			else
				step_q <= '0;
			// busy up on accepted run, down once the marker is seen
			if (state_q == IDLE && run)
				busy <= 1'b1;
			else if (state_q == READ_ROWS && ctl.end_seen)
				busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/row_window.sv
// images are contiguous from address 0, the read address runs one word ahead while streaming
`timescale 1ns/10ps
`default_nettype none

module row_window import bnn_conv_pkg::*; (
	input  wire                     clk,
	input  wire                     reset_b,
	conv_ctrl_if.datapath           ctl,
	output addr_t                   rd_addr,
	input  wire word_t              rd_data,
	output addr_t                   w_addr,
	input  wire word_t              w_data,
	output kernel_t                 kernel,
	output logic [KERNEL_SIZE-1:0]  column,
	output col_idx_t                col_idx,
	output logic                    col_valid,
	output col_idx_t                out_cols
);

	// weight fetch in flight, address then data
	logic [1:0] wt_pend_q;
	// image size, 3 to 16 fits five bits
	logic [4:0] n_rows_q;
	logic [4:0] n_cols_q;
	// rows shifted in so far for this image
	logic [4:0] rows_loaded_q;
	col_idx_t   col_cnt_q;
	// entry 0 is the oldest row of the window
	word_t      row_buf_q [KERNEL_SIZE];
	// third fill closes the read burst
	logic       burst_end;

	// status back to the controller
	assign ctl.end_seen = (rd_data == END_MARKER);
	assign ctl.last_col = ({1'b0, col_cnt_q} == n_cols_q - 5'd1);
	assign ctl.last_row = (rows_loaded_q == n_rows_q);
	// width of one output row
	assign out_cols     = col_idx_t'(n_cols_q - 5'(KERNEL_SIZE - 1));
	// address already sits on the next row word here
	assign burst_end    = (rows_loaded_q == 5'(KERNEL_SIZE - 1));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory addressing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			rd_addr   <= '0;
			w_addr    <= '0;
			wt_pend_q <= '0;
		end else begin
			// marker ends the run, next run starts over at 0
			if (ctl.store_rows && ctl.end_seen)
				rd_addr <= '0;
			else if (ctl.load_weights || ctl.store_rows || ctl.store_cols ||
					(ctl.fill_row && !burst_end) || ctl.next_image)
				rd_addr <= rd_addr + 1'b1;
			// weight address up for one cycle only
			w_addr    <= ctl.load_weights ? WEIGHT_ADDR : '0;
			wt_pend_q <= {wt_pend_q[0], ctl.load_weights};
		end
	end

	// kernel and dimensions
	always_ff @(posedge clk) begin
		if (wt_pend_q[1])
			kernel <= kernel_t'(w_data);
		if (ctl.store_rows)
			n_rows_q <= rd_data[4:0];
		if (ctl.store_cols)
			n_cols_q <= rd_data[4:0];
	end

	// three-row buffer, newest row enters at the bottom
	always_ff @(posedge clk) begin
		if (ctl.fill_row) begin
			for (int dy = 0; dy < KERNEL_SIZE - 1; dy++)
				row_buf_q[dy] <= row_buf_q[dy + 1];
			row_buf_q[KERNEL_SIZE - 1] <= rd_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// counters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			rows_loaded_q <= '0;
			col_cnt_q     <= '0;
			col_valid     <= 1'b0;
		end else begin
			if (ctl.store_rows)
				rows_loaded_q <= '0;
			else if (ctl.fill_row)
				rows_loaded_q <= rows_loaded_q + 1'b1;
			// wraps after the final column, ready for the next row
			if (ctl.sweep)
				col_cnt_q <= ctl.last_col ? '0 : col_cnt_q + 1'b1;
			col_valid <= ctl.sweep;
		end
	end

	// one column of the window per sweep cycle, tagged
	always_ff @(posedge clk) begin
		if (ctl.sweep) begin
			for (int dy = 0; dy < KERNEL_SIZE; dy++)
				column[dy] <= row_buf_q[dy][col_cnt_q];
			col_idx <= col_cnt_q;
		end
	end

endmodule

`default_nettype wire

// File: hw/xnor_array.sv
// columns of one row must enter in order from index 0, a new row restarts the window
`timescale 1ns/10ps
`default_nettype none

module xnor_array import bnn_conv_pkg::*; (
	input  wire                     clk,
	input  wire                     reset_b,
	input  wire kernel_t            kernel,
	input  wire [KERNEL_SIZE-1:0]   column,
	input  wire col_idx_t           col_idx,
	input  wire                     col_valid,
	output logic                    res_bit,
	output col_idx_t                res_idx,
	output logic                    res_valid
);

	// cell_q[dy][dx], dx 0 is the window's left column
	logic [KERNEL_SIZE-1:0] cell_q [KERNEL_SIZE];
	logic [KERNEL_SIZE-1:0] miss   [KERNEL_SIZE];
	logic [1:0]             row_sum_q [KERNEL_SIZE];
	count_t                 total;
	count_t                 count_q;
	// columns seen in this row, saturating
	logic [1:0]             fill_q;
	logic [1:0]             fill_n;
	// tag and valid travel beside the data
	col_idx_t               tag1_q, tag2_q, tag3_q;
	logic                   v1_q, v2_q, v3_q;

	// mismatch per cell
	always_comb begin
		for (int dy = 0; dy < KERNEL_SIZE; dy++)
			for (int dx = 0; dx < KERNEL_SIZE; dx++)
				miss[dy][dx] = cell_q[dy][dx] ^ kernel[KERNEL_SIZE * dy + dx];
	end

	// second adder stage, three row sums
	always_comb begin
		total = '0;
		for (int dy = 0; dy < KERNEL_SIZE; dy++)
			total = total + count_t'(row_sum_q[dy]);
	end

	// index 0 starts a fresh row
	assign fill_n = (col_idx == '0) ? 2'd1 : ((fill_q == 2'd3) ? 2'd3 : fill_q + 2'd1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data pipeline
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		// newest column enters on the right
		if (col_valid) begin
			for (int dy = 0; dy < KERNEL_SIZE; dy++)
				cell_q[dy] <= {column[dy], cell_q[dy][KERNEL_SIZE-1:1]};
			// rebase tag to the left column
			tag1_q <= col_idx - col_idx_t'(KERNEL_SIZE - 1);
		end
		for (int dy = 0; dy < KERNEL_SIZE; dy++)
			row_sum_q[dy] <= 2'($countones(miss[dy]));
		tag2_q  <= tag1_q;
		count_q <= total;
		tag3_q  <= tag2_q;
		// majority of matches gives a 1
		res_bit <= (count_q <= count_t'(MAJORITY_LIMIT));
		res_idx <= tag3_q;
	end

	// valid chain
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			fill_q    <= '0;
			v1_q      <= 1'b0;
			v2_q      <= 1'b0;
			v3_q      <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			if (col_valid)
				fill_q <= fill_n;
			v1_q      <= col_valid && (fill_n == 2'd3) &&
					(col_idx >= col_idx_t'(KERNEL_SIZE - 1));
			v2_q      <= v1_q;
			v3_q      <= v2_q;
			res_valid <= v3_q;
		end
	end

endmodule

`default_nettype wire

// File: hw/output_row_writer.sv
// one word per output row, bits at or above out_cols stay 0, write address restarts per run
`timescale 1ns/10ps
`default_nettype none

module output_row_writer import bnn_conv_pkg::*; (
	input  wire            clk,
	input  wire            reset_b,
	input  wire            res_bit,
	input  wire col_idx_t  res_idx,
	input  wire            res_valid,
	input  wire col_idx_t  out_cols,
	input  wire            flush_row,
	// busy level, its fall ends the run
	input  wire            next_run,
	output addr_t          wr_addr,
	output word_t          wr_data,
	output logic           wr_en
);

	word_t row_q;
	word_t row_n;
	logic  busy_q;
	logic  run_end;

	assign run_end = busy_q && !next_run;

	// the last result lands in the same cycle as flush_row
	always_comb begin
		row_n = row_q;
		if (res_valid && (res_idx < out_cols))
			row_n[res_idx] = res_bit;
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			row_q   <= '0;
			wr_en   <= 1'b0;
			wr_addr <= '0;
			busy_q  <= 1'b0;
		end else begin
			busy_q <= next_run;
			wr_en  <= flush_row;
			// emptied for the next row
			row_q  <= flush_row ? '0 : row_n;
			// step past each written word
			if (run_end)
				wr_addr <= '0;
			else if (wr_en)
				wr_addr <= wr_addr + 1'b1;
		end
	end

	// word held for the write cycle
	always_ff @(posedge clk) begin
		if (flush_row)
			wr_data <= row_n;
	end

endmodule

`default_nettype wire

// File: hw/bnn_conv_top.sv
// both memories answer one cycle after the address, no back-pressure on any port
`timescale 1ns/10ps
`default_nettype none

module bnn_conv_top import bnn_conv_pkg::*; (
	input  wire         clk,
	input  wire         reset_b,
	input  wire         run,
	output logic        busy,
	output addr_t       rd_addr,
	input  wire word_t  rd_data,
	output addr_t       w_addr,
	input  wire word_t  w_data,
	output addr_t       wr_addr,
	output word_t       wr_data,
	output logic        wr_en
);

	// controller to datapath
	conv_ctrl_if ctl ();

	// window to array
	kernel_t                kernel;
	logic [KERNEL_SIZE-1:0] column;
	col_idx_t               col_idx;
	logic                   col_valid;
	col_idx_t               out_cols;

	// array to writer
	logic                   res_bit;
	col_idx_t               res_idx;
	logic                   res_valid;

	conv_controller u_ctrl (
		.clk       (clk),
		.reset_b   (reset_b),
		.run       (run),
		.busy      (busy),
		.ctl       (ctl)
	);

	row_window u_window (
		.clk       (clk),
		.reset_b   (reset_b),
		.ctl       (ctl),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.w_addr    (w_addr),
		.w_data    (w_data),
		.kernel    (kernel),
		.column    (column),
		.col_idx   (col_idx),
		.col_valid (col_valid),
		.out_cols  (out_cols)
	);

	xnor_array u_array (
		.clk       (clk),
		.reset_b   (reset_b),
		.kernel    (kernel),
		.column    (column),
		.col_idx   (col_idx),
		.col_valid (col_valid),
		.res_bit   (res_bit),
		.res_idx   (res_idx),
		.res_valid (res_valid)
	);

	output_row_writer u_writer (
		.clk       (clk),
		.reset_b   (reset_b),
		.res_bit   (res_bit),
		.res_idx   (res_idx),
		.res_valid (res_valid),
		.out_cols  (out_cols),
		.flush_row (ctl.flush_row),
		.next_run  (busy),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_en     (wr_en)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// free-running 40 ns clock starting low, never stops on its own
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk
);

	// first rising edge at 20 ns
	initial clk = 1'b0;

	// half period of 20 ns
	always #20 clk = ~clk;

endmodule

`default_nettype wire

// File: tests/bnn_conv_chk.sv
// sampled on the rising clock edge, write rules only apply out of reset
`timescale 1ns/10ps
`default_nettype none

module bnn_conv_chk import bnn_conv_pkg::*; (
	input wire        clk,
	input wire        reset_b,
	input wire        busy,
	input wire        wr_en,
	input wire addr_t wr_addr
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output port rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// writes only inside a run
	write_in_run: assert property (@(posedge clk) disable iff (!reset_b)
		wr_en |-> busy)
		else $error("wr_en high while busy is low");

	// one address step per written word
	addr_step: assert property (@(posedge clk) disable iff (!reset_b)
		wr_en |=> (wr_addr == ($past(wr_addr) + 12'd1)))
		else $error("wr_addr did not advance by one after a write");

	// controller comes out of reset idle
	idle_after_reset: assert property (@(posedge clk)
		!reset_b |=> !busy)
		else $error("busy high right after reset");

endmodule

// checker rides on every instance of the top level
bind bnn_conv_top bnn_conv_chk u_chk (
	.clk     (clk),
	.reset_b (reset_b),
	.busy    (busy),
	.wr_en   (wr_en),
	.wr_addr (wr_addr)
);

`default_nettype wire

// File: tests/bnn_conv_tb.sv
// memories modeled here answer one cycle after the address, every run rereads input from address 0
`timescale 1ns/10ps
`default_nettype none

module bnn_conv_tb import bnn_conv_pkg::*; ();

	logic    clk;
	logic    reset_b;
	logic    run;
	logic    busy;
	addr_t   rd_addr;
	word_t   rd_data = '0;
	addr_t   w_addr;
	word_t   w_data = '0;
	addr_t   wr_addr;
	word_t   wr_data;
	logic    wr_en;

	// memory models, address held for one cycle
	word_t   in_mem [4096];
	word_t   wt_mem [4096];
	addr_t   rd_addr_hold = '0;
	addr_t   w_addr_hold = '0;

	// expected writes of the current run, in order
	addr_t   exp_addr [$];
	word_t   exp_data [$];
	int      writes_seen;
	int      errors;
	addr_t   load_ptr;
	addr_t   next_wr;
	kernel_t cur_kernel;
	// rows of the image being loaded
	word_t   img_rows [16];
	logic [31:0] rng_state;

	tb_clock_gen u_clkgen (
		.clk (clk)
	);

	bnn_conv_top u_dut (
		.clk     (clk),
		.reset_b (reset_b),
		.run     (run),
		.busy    (busy),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.w_addr  (w_addr),
		.w_data  (w_data),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// synchronous memories
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address seen mid cycle, data out mid next cycle
	always @(negedge clk) begin
		rd_data      <= in_mem[rd_addr_hold];
		w_data       <= wt_mem[w_addr_hold];
		rd_addr_hold <= rd_addr;
		w_addr_hold  <= w_addr;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// error handling and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic stop_run(input string why);
		if (why.len() > 0)
			$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
			stop_run("");
		end
	endtask

	// each write against the head of the expected list
	always @(negedge clk) begin
		addr_t a;
		word_t d;
		if (reset_b === 1'b1 && wr_en === 1'b1) begin
			if (exp_data.size() == 0) begin
				stop_run("write seen with no expected word left");
			end else begin
				a = exp_addr.pop_front();
				d = exp_data.pop_front();
				check_value("wr_addr", 32'(wr_addr), 32'(a));
				check_value("wr_data", 32'(wr_data), 32'(d));
				writes_seen++;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and reference
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// majority of matches between kernel and 3x3 window gives a 1
	function automatic word_t expected_row(input int r, input int cols);
		word_t row;
		int    miss;
		row = '0;
		for (int c = 0; c <= cols - KERNEL_SIZE; c++) begin
			miss = 0;
			for (int dy = 0; dy < KERNEL_SIZE; dy++)
				for (int dx = 0; dx < KERNEL_SIZE; dx++)
					if (img_rows[r + dy][c + dx] != cur_kernel[KERNEL_SIZE * dy + dx])
						miss++;
			row[c] = (miss <= MAJORITY_LIMIT);
		end
		return row;
	endfunction

	// fill depends on every address bit, never the marker
	task automatic new_run();
		for (int i = 0; i < 4096; i++) begin
			in_mem[i] = 16'h5000 ^ word_t'(i);
			wt_mem[i] = 16'ha000 ^ word_t'(i);
		end
		load_ptr    = '0;
		next_wr     = '0;
		writes_seen = 0;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic set_weights(input kernel_t k);
		cur_kernel            = k;
		wt_mem[WEIGHT_ADDR]   = word_t'(k);
	endtask

	// image words plus its expected output rows
	task automatic add_image(input int rows, input int cols, input bit all_ones);
		word_t mask;
		mask = word_t'((32'd1 << cols) - 32'd1);
		in_mem[load_ptr]         = word_t'(rows);
		in_mem[load_ptr + 12'd1] = word_t'(cols);
		load_ptr = load_ptr + 12'd2;
		for (int r = 0; r < rows; r++) begin
			if (all_ones)
				img_rows[r] = mask;
			else
				img_rows[r] = word_t'(next_rand()) & mask;
			in_mem[load_ptr] = img_rows[r];
			load_ptr = load_ptr + 12'd1;
		end
		for (int r = 0; r <= rows - KERNEL_SIZE; r++) begin
			exp_addr.push_back(next_wr);
			exp_data.push_back(expected_row(r, cols));
			next_wr = next_wr + 12'd1;
		end
	endtask

	task automatic end_marker();
		in_mem[load_ptr] = END_MARKER;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (busy !== level) begin
			if (n >= limit) begin
				if (level)
					stop_run("busy did not rise after the run strobe");
				else
					stop_run("busy did not fall, the run never finished");
			end
			@(negedge clk);
			n++;
		end
	endtask

	// one strobe, then the whole run until busy drops
	task automatic do_run();
		@(negedge clk);
		run = 1'b1;
		@(negedge clk);
		run = 1'b0;
		wait_busy(1'b1, 4);
		wait_busy(1'b0, 5000);
		// quiet gap, no write may trail the run
		repeat (3) @(negedge clk);
		check_value("write count", 32'(writes_seen), 32'(next_wr));
		check_value("wr_addr", 32'(wr_addr), 32'd0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		run         = 1'b0;
		reset_b     = 1'b0;
		errors      = 0;
		writes_seen = 0;
		rng_state   = 32'hb930;
		new_run();
		repeat (10) @(negedge clk);
		reset_b = 1'b1;
		@(negedge clk);

		// idle outputs after reset
		check_value("busy", 32'(busy), 32'd0);
		check_value("wr_en", 32'(wr_en), 32'd0);
		check_value("rd_addr", 32'(rd_addr), 32'd0);
		check_value("w_addr", 32'(w_addr), 32'd0);
		check_value("wr_addr", 32'(wr_addr), 32'd0);

		// smallest image, one output bit
		new_run();
		set_weights(kernel_t'(next_rand()));
		add_image(3, 3, 1'b0);
		end_marker();
		do_run();

		// full size, 14 rows of 14 bits
		new_run();
		set_weights(kernel_t'(next_rand()));
		add_image(16, 16, 1'b0);
		end_marker();
		do_run();

		// three images back to back
		new_run();
		set_weights(kernel_t'(next_rand()));
		add_image(5, 9, 1'b0);
		add_image(16, 3, 1'b0);
		add_image(7, 16, 1'b0);
		end_marker();
		do_run();

		// weight extremes over an all-ones image
		new_run();
		set_weights('1);
		add_image(6, 11, 1'b1);
		end_marker();
		do_run();
		new_run();
		set_weights('0);
		add_image(6, 11, 1'b1);
		end_marker();
		do_run();

		// marker alone, then a fresh run from address 0
		new_run();
		set_weights(kernel_t'(next_rand()));
		end_marker();
		do_run();
		new_run();
		set_weights(kernel_t'(next_rand()));
		add_image(4, 5, 1'b0);
		end_marker();
		do_run();

		if (errors == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			stop_run("errors counted during the run");
		end
	end

endmodule

`default_nettype wire

// File: bnn_conv.f
hw/bnn_conv_pkg.sv
hw/conv_ctrl_if.sv
hw/conv_controller.sv
hw/row_window.sv
hw/xnor_array.sv
hw/output_row_writer.sv
hw/bnn_conv_top.sv
tests/tb_clock_gen.sv
tests/bnn_conv_chk.sv
tests/bnn_conv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bnn_conv testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=sim_bnn_conv

verilator --binary --timing --assert \
	--top-module bnn_conv_tb \
	-f bnn_conv.f \
	-Mdir "${OBJ_DIR}" -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./${OBJ_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
	echo "simulation exited with status ${sim_status}"
	exit 1
fi

if grep -q "^Simulation passed$" "${LOG_FILE}"; then
	echo "result: PASS"
	exit 0
fi
echo "result: FAIL"
exit 1
